// ==== rtl/sysctl_consts.svh ====
`ifndef SYSCTL_CONSTS_SVH
`define SYSCTL_CONSTS_SVH

`define SYSCTL_I2C_ADDR         7'h3C
`define SYSCTL_NUM_REGS         16      // Pointer wraps here
`define SYSCTL_FIRST_RO         12

`define SYSCTL_REG_CPU_PLL_MUL  4'd0
`define SYSCTL_DEF_CPU_PLL_MUL  8'd46
`define SYSCTL_REG_CPU_PLL_DIV  4'd1
`define SYSCTL_DEF_CPU_PLL_DIV  8'h22   // OD 1, N 2
`define SYSCTL_REG_SOC_PLL_MUL  4'd2
`define SYSCTL_DEF_SOC_PLL_MUL  8'd30
`define SYSCTL_REG_SOC_PLL_DIV  4'd3
`define SYSCTL_DEF_SOC_PLL_DIV  8'h21   // OD 1, N 1
`define SYSCTL_REG_PLL_CTRL     4'd4
`define SYSCTL_DEF_PLL_CTRL     8'h00
`define SYSCTL_REG_SPI_DIV      4'd5
`define SYSCTL_DEF_SPI_DIV      8'h04
`define SYSCTL_REG_DBG_CTRL     4'd6
`define SYSCTL_DEF_DBG_CTRL     8'h05
`define SYSCTL_REG_OUTPUT_MUX   4'd7
`define SYSCTL_DEF_OUTPUT_MUX   8'h03
`define SYSCTL_REG_CTRL_WORD    4'd8    // Bytes 8 to 11, LSB first
`define SYSCTL_DEF_CTRL_WORD    32'h0000_0000
`define SYSCTL_REG_STATUS       4'd12   // Bytes 12 to 15, LSB first

`define SYSCTL_MUX_VGA_BIT      0
`define SYSCTL_MUX_I2S_BIT      1

`endif

// ==== rtl/sysctl_pkg.sv ====
package sysctl_pkg;

    // Writable part of the register map
    typedef struct packed {
        logic [7:0]  cpu_pll_mul;
        logic [7:0]  cpu_pll_div;
        logic [7:0]  soc_pll_mul;
        logic [7:0]  soc_pll_div;
        logic [7:0]  pll_ctrl;
        logic [7:0]  spi_div;
        logic [7:0]  dbg_ctrl;
        logic [7:0]  output_mux;
        logic [31:0] ctrl_word;
    } cfg_t;

    typedef struct packed {
        logic scl;
        logic sda;
    } i2c_lines_t;

    // t set means the pad is an input
    typedef struct packed {
        logic [7:0] o;
        logic [7:0] t;
    } pad_drive_t;

    typedef struct packed {
        logic tx;
        logic tx_t;
        logic tx_en;
        logic tx_en_t;
    } cdbus_drive_t;

    typedef struct packed {
        logic lrclk;
        logic sclk;
        logic sdata;
    } i2s_out_t;

endpackage

// ==== rtl/sysctl_sync.sv ====
module sysctl_sync #(
    parameter type T = logic
) (
    input  logic clk_25m_i,
    input  logic rst_i,
    input  T     d_i,
    output T     q_o
);

    T meta_q;

    always_ff @(posedge clk_25m_i) begin
        if (rst_i) begin
            meta_q <= T'(0);
            q_o    <= T'(0);
        end else begin
            meta_q <= d_i;
            q_o    <= meta_q;
        end
    end

endmodule

// ==== rtl/i2c_bus_frontend.sv ====
module i2c_bus_frontend (
    input  logic                   clk_25m_i,
    input  logic                   rst_i,
    input  sysctl_pkg::i2c_lines_t lines_i,
    output logic                   start_o,
    output logic                   stop_o,
    output logic                   scl_rise_o,
    output logic                   scl_fall_o,
    output logic                   sda_bit_o
);

    sysctl_pkg::i2c_lines_t cur;
    sysctl_pkg::i2c_lines_t prev_q;

    sysctl_sync #(
        .T(sysctl_pkg::i2c_lines_t)
    ) u_line_sync (
        .clk_25m_i(clk_25m_i),
        .rst_i    (rst_i),
        .d_i      (lines_i),
        .q_o      (cur)
    );

    // Idle bus is both lines high
    always_ff @(posedge clk_25m_i) begin
        if (rst_i) begin
            prev_q.scl <= 1'b1;
            prev_q.sda <= 1'b1;
        end else begin
            prev_q <= cur;
        end
    end

    // SDA edges only count with SCL held high across both samples
    assign start_o    = prev_q.scl && cur.scl && prev_q.sda && !cur.sda;
    assign stop_o     = prev_q.scl && cur.scl && !prev_q.sda && cur.sda;
    assign scl_rise_o = !prev_q.scl && cur.scl;
    assign scl_fall_o = prev_q.scl && !cur.scl;
    assign sda_bit_o  = cur.sda;

endmodule

// ==== rtl/i2c_reg_slave.sv ====
`include "sysctl_consts.svh"

module i2c_reg_slave (
    input  logic       clk_25m_i,
    input  logic       rst_i,
    input  logic       start_i,
    input  logic       stop_i,
    input  logic       scl_rise_i,
    input  logic       scl_fall_i,
    input  logic       sda_bit_i,
    input  logic [7:0] rd_data_i,
    output logic       wr_en_o,
    output logic [3:0] idx_o,
    output logic [7:0] wr_data_o,
    output logic       sda_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_PTR,
        S_WRITE,
        S_READ,
        S_ACK
    } state_e;

    state_e     state_q;
    state_e     ack_nxt_q;      // Where a write-side ACK leads
    logic [3:0] bit_cnt_q;
    logic [7:0] shift_q;
    logic [3:0] ptr_q;
    logic       rd_q;
    logic       byte_done;
    logic [3:0] ptr_inc;

    assign byte_done = scl_fall_i && (bit_cnt_q == 4'd8);
    assign ptr_inc   = (ptr_q == 4'(`SYSCTL_NUM_REGS - 1)) ? 4'd0 : ptr_q + 4'd1;

    assign wr_en_o   = (state_q == S_WRITE) && byte_done;
    assign idx_o     = ptr_q;
    assign wr_data_o = shift_q;

    always_ff @(posedge clk_25m_i) begin
        if (rst_i) begin
            state_q   <= S_IDLE;
            ack_nxt_q <= S_IDLE;
            bit_cnt_q <= '0;
            shift_q   <= '0;
            ptr_q     <= '0;
            rd_q      <= 1'b0;
            sda_o     <= 1'b1;
        end else if (start_i) begin
            state_q   <= S_ADDR;    // Also a repeated start
            bit_cnt_q <= '0;
            sda_o     <= 1'b1;
        end else if (stop_i) begin
            state_q <= S_IDLE;
            sda_o   <= 1'b1;
        end else begin
            // Master to slave bits, MSB first
            if (state_q inside {S_ADDR, S_PTR, S_WRITE} && scl_rise_i &&
                bit_cnt_q != 4'd8) begin
                shift_q   <= {shift_q[6:0], sda_bit_i};
                bit_cnt_q <= bit_cnt_q + 4'd1;
            end

            case (state_q)
                S_ADDR: begin
                    if (byte_done) begin
                        if (shift_q[7:1] == `SYSCTL_I2C_ADDR) begin
                            rd_q      <= shift_q[0];
                            ack_nxt_q <= S_PTR;
                            sda_o     <= 1'b0;
                            state_q   <= S_ACK;
                        end else begin
                            state_q <= S_IDLE;  // Not ours
                        end
                    end
                end
                S_PTR: begin
                    if (byte_done) begin
                        ptr_q     <= shift_q[3:0];
                        ack_nxt_q <= S_WRITE;
                        sda_o     <= 1'b0;
                        state_q   <= S_ACK;
                    end
                end
                S_WRITE: begin
                    if (byte_done) begin
                        ptr_q   <= ptr_inc;     // Bank takes the byte this cycle
                        sda_o   <= 1'b0;
                        state_q <= S_ACK;
                    end
                end
                S_ACK: begin
                    // On a read the line is either our own ACK or the master's
                    if (scl_rise_i && rd_q && sda_bit_i) begin
                        state_q <= S_IDLE;      // NACK ends the read
                    end else if (scl_fall_i) begin
                        bit_cnt_q <= '0;
                        if (rd_q) begin
                            sda_o   <= rd_data_i[7];
                            shift_q <= {rd_data_i[6:0], 1'b0};
                            ptr_q   <= ptr_inc;
                            state_q <= S_READ;
                        end else begin
                            sda_o   <= 1'b1;
                            state_q <= ack_nxt_q;
                        end
                    end
                end
                S_READ: begin
                    if (scl_fall_i) begin
                        if (bit_cnt_q == 4'd7) begin
                            sda_o   <= 1'b1;    // Let the master answer
                            state_q <= S_ACK;
                        end else begin
                            sda_o     <= shift_q[7];
                            shift_q   <= {shift_q[6:0], 1'b0};
                            bit_cnt_q <= bit_cnt_q + 4'd1;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== rtl/ctrl_reg_bank.sv ====
`include "sysctl_consts.svh"

module ctrl_reg_bank (
    input  logic              clk_25m_i,
    input  logic              rst_i,
    input  logic              wr_en_i,
    input  logic [3:0]        idx_i,
    input  logic [7:0]        wr_data_i,
    input  logic [31:0]       status_i,
    output logic [7:0]        rd_data_o,
    output sysctl_pkg::cfg_t  cfg_o
);

    localparam logic [31:0] CTRL_WORD_DEF = `SYSCTL_DEF_CTRL_WORD;

    logic [7:0] regs_q [`SYSCTL_FIRST_RO];
    logic       is_rw;

    assign is_rw = idx_i < `SYSCTL_FIRST_RO;

    always_ff @(posedge clk_25m_i) begin
        if (rst_i) begin
            regs_q[`SYSCTL_REG_CPU_PLL_MUL] <= `SYSCTL_DEF_CPU_PLL_MUL;
            regs_q[`SYSCTL_REG_CPU_PLL_DIV] <= `SYSCTL_DEF_CPU_PLL_DIV;
            regs_q[`SYSCTL_REG_SOC_PLL_MUL] <= `SYSCTL_DEF_SOC_PLL_MUL;
            regs_q[`SYSCTL_REG_SOC_PLL_DIV] <= `SYSCTL_DEF_SOC_PLL_DIV;
            regs_q[`SYSCTL_REG_PLL_CTRL]    <= `SYSCTL_DEF_PLL_CTRL;
            regs_q[`SYSCTL_REG_SPI_DIV]     <= `SYSCTL_DEF_SPI_DIV;
            regs_q[`SYSCTL_REG_DBG_CTRL]    <= `SYSCTL_DEF_DBG_CTRL;
            regs_q[`SYSCTL_REG_OUTPUT_MUX]  <= `SYSCTL_DEF_OUTPUT_MUX;
            for (int i = 0; i < 4; i++) begin
                regs_q[`SYSCTL_REG_CTRL_WORD + i] <= CTRL_WORD_DEF[8*i +: 8];
            end
        end else if (wr_en_i && is_rw) begin
            regs_q[idx_i] <= wr_data_i;     // Status range drops writes
        end
    end

    // Indices 12 to 15 map to status bytes 0 to 3
    assign rd_data_o = is_rw ? regs_q[idx_i] : status_i[8*idx_i[1:0] +: 8];

    assign cfg_o.cpu_pll_mul = regs_q[`SYSCTL_REG_CPU_PLL_MUL];
    assign cfg_o.cpu_pll_div = regs_q[`SYSCTL_REG_CPU_PLL_DIV];
    assign cfg_o.soc_pll_mul = regs_q[`SYSCTL_REG_SOC_PLL_MUL];
    assign cfg_o.soc_pll_div = regs_q[`SYSCTL_REG_SOC_PLL_DIV];
    assign cfg_o.pll_ctrl    = regs_q[`SYSCTL_REG_PLL_CTRL];
    assign cfg_o.spi_div     = regs_q[`SYSCTL_REG_SPI_DIV];
    assign cfg_o.dbg_ctrl    = regs_q[`SYSCTL_REG_DBG_CTRL];
    assign cfg_o.output_mux  = regs_q[`SYSCTL_REG_OUTPUT_MUX];
    assign cfg_o.ctrl_word   = {regs_q[`SYSCTL_REG_CTRL_WORD + 3],
                                regs_q[`SYSCTL_REG_CTRL_WORD + 2],
                                regs_q[`SYSCTL_REG_CTRL_WORD + 1],
                                regs_q[`SYSCTL_REG_CTRL_WORD]};

endmodule

// ==== rtl/pad_mux.sv ====
`include "sysctl_consts.svh"

module pad_mux (
    input  logic [7:0]               output_mux_i,
    input  logic [7:0]               vga_rgb_i,
    input  sysctl_pkg::pad_drive_t   gpio_i,
    input  sysctl_pkg::i2s_out_t     i2s_i,
    input  sysctl_pkg::cdbus_drive_t cdbus_i,
    output sysctl_pkg::pad_drive_t   pad_o,
    output logic [2:0]               audio_o,
    output logic [2:0]               audio_t_o
);

    logic vga_sel;
    logic i2s_sel;

    assign vga_sel = output_mux_i[`SYSCTL_MUX_VGA_BIT];
    assign i2s_sel = output_mux_i[`SYSCTL_MUX_I2S_BIT];

    always_comb begin
        if (vga_sel) begin
            pad_o.o = vga_rgb_i;
            pad_o.t = '0;               // VGA only drives
        end else begin
            pad_o = gpio_i;
        end
    end

    // Pin 0 lrclk or tx, pin 1 sclk or tx_en, pin 2 sdata or rx
    always_comb begin
        audio_o[2] = i2s_i.sdata;
        if (i2s_sel) begin
            audio_o[1:0] = {i2s_i.sclk, i2s_i.lrclk};
            audio_t_o    = 3'b000;
        end else begin
            audio_o[1:0] = {cdbus_i.tx_en, cdbus_i.tx};
            audio_t_o    = {1'b1, cdbus_i.tx_en_t, cdbus_i.tx_t};  // Data pin receives
        end
    end

endmodule

// ==== rtl/sysctl_top.sv ====
module sysctl_top (
    input  logic                     clk_25m_i,
    input  logic                     rst_i,
    input  logic                     scl_i,
    input  logic                     sda_i,
    output logic                     sda_o,
    input  logic [31:0]              status_i,
    input  logic [7:0]               vga_rgb_i,
    input  sysctl_pkg::pad_drive_t   gpio_i,
    input  sysctl_pkg::i2s_out_t     i2s_i,
    input  sysctl_pkg::cdbus_drive_t cdbus_i,
    output sysctl_pkg::cfg_t         cfg_o,
    output sysctl_pkg::pad_drive_t   pad_o,
    output logic [2:0]               audio_o,
    output logic [2:0]               audio_t_o
);

    sysctl_pkg::i2c_lines_t lines;
    logic                   start;
    logic                   stop;
    logic                   scl_rise;
    logic                   scl_fall;
    logic                   sda_bit;
    logic [31:0]            status_sync;
    logic                   wr_en;
    logic [3:0]             idx;
    logic [7:0]             wr_data;
    logic [7:0]             rd_data;

    assign lines.scl = scl_i;
    assign lines.sda = sda_i;

    i2c_bus_frontend u_frontend (
        .clk_25m_i (clk_25m_i),
        .rst_i     (rst_i),
        .lines_i   (lines),
        .start_o   (start),
        .stop_o    (stop),
        .scl_rise_o(scl_rise),
        .scl_fall_o(scl_fall),
        .sda_bit_o (sda_bit)
    );

    // Status comes from the SoC clock domain
    sysctl_sync #(
        .T(logic [31:0])
    ) u_status_sync (
        .clk_25m_i(clk_25m_i),
        .rst_i    (rst_i),
        .d_i      (status_i),
        .q_o      (status_sync)
    );

    i2c_reg_slave u_slave (
        .clk_25m_i (clk_25m_i),
        .rst_i     (rst_i),
        .start_i   (start),
        .stop_i    (stop),
        .scl_rise_i(scl_rise),
        .scl_fall_i(scl_fall),
        .sda_bit_i (sda_bit),
        .rd_data_i (rd_data),
        .wr_en_o   (wr_en),
        .idx_o     (idx),
        .wr_data_o (wr_data),
        .sda_o     (sda_o)
    );

    ctrl_reg_bank u_bank (
        .clk_25m_i(clk_25m_i),
        .rst_i    (rst_i),
        .wr_en_i  (wr_en),
        .idx_i    (idx),
        .wr_data_i(wr_data),
        .status_i (status_sync),
        .rd_data_o(rd_data),
        .cfg_o    (cfg_o)
    );

    pad_mux u_pad_mux (
        .output_mux_i(cfg_o.output_mux),
        .vga_rgb_i   (vga_rgb_i),
        .gpio_i      (gpio_i),
        .i2s_i       (i2s_i),
        .cdbus_i     (cdbus_i),
        .pad_o       (pad_o),
        .audio_o     (audio_o),
        .audio_t_o   (audio_t_o)
    );

endmodule

// ==== dv/sysctl_checker.sv ====
`include "sysctl_consts.svh"

module sysctl_checker (
    input logic                   clk_25m_i,
    input logic                   rst_i,
    input logic                   scl_fall_i,
    input logic                   sda_out_i,
    input sysctl_pkg::cfg_t       cfg_i,
    input sysctl_pkg::pad_drive_t pad_i
);
    timeunit 1ns;
    timeprecision 1ps;

    sysctl_pkg::cfg_t cfg_def;
    int               fail_count = 0;

    assign cfg_def = {`SYSCTL_DEF_CPU_PLL_MUL, `SYSCTL_DEF_CPU_PLL_DIV,
                      `SYSCTL_DEF_SOC_PLL_MUL, `SYSCTL_DEF_SOC_PLL_DIV,
                      `SYSCTL_DEF_PLL_CTRL, `SYSCTL_DEF_SPI_DIV,
                      `SYSCTL_DEF_DBG_CTRL, `SYSCTL_DEF_OUTPUT_MUX,
                      `SYSCTL_DEF_CTRL_WORD};

    reset_defaults: assert property (@(posedge clk_25m_i) $fell(rst_i) |-> cfg_i == cfg_def)
        else begin
            $error("cfg_o differs from the reset defaults right after reset");
            fail_count++;
        end

    // VGA owns the shared pins as outputs
    vga_drives: assert property (@(posedge clk_25m_i) disable iff (rst_i)
        cfg_i.output_mux[`SYSCTL_MUX_VGA_BIT] |-> pad_i.t == '0)
        else begin
            $error("shared pins not all outputs while VGA is selected");
            fail_count++;
        end

    sda_after_fall: assert property (@(posedge clk_25m_i) disable iff (rst_i)
        $changed(sda_out_i) |-> $past(scl_fall_i) || $past(rst_i))
        else begin
            $error("sda_o changed without a preceding SCL fall");
            fail_count++;
        end

endmodule

bind sysctl_top sysctl_checker u_checker (
    .clk_25m_i (clk_25m_i),
    .rst_i     (rst_i),
    .scl_fall_i(scl_fall),
    .sda_out_i (sda_o),
    .cfg_i     (cfg_o),
    .pad_i     (pad_o)
);

// ==== dv/sysctl_tb.sv ====
`include "sysctl_consts.svh"

module sysctl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PHASE = 16;      // Clocks per SCL phase

    logic                     clk_25m;
    logic                     rst;
    logic                     scl;
    logic                     sda_drv;
    logic                     sda_out;
    logic                     sda_line;
    logic [31:0]              status;
    logic [7:0]               vga_rgb;
    sysctl_pkg::pad_drive_t   gpio;
    sysctl_pkg::i2s_out_t     i2s;
    sysctl_pkg::cdbus_drive_t cdbus;
    sysctl_pkg::cfg_t         cfg;
    sysctl_pkg::pad_drive_t   pad;
    logic [2:0]               audio;
    logic [2:0]               audio_t;

    logic [7:0] data_buf [16];
    int         data_cnt;
    int         errs_now;
    int         n_tests;
    int         n_failed;
    int         n_errors;

    assign sda_line = sda_drv & sda_out;    // Open drain bus

    sysctl_top dut (
        .clk_25m_i(clk_25m),
        .rst_i    (rst),
        .scl_i    (scl),
        .sda_i    (sda_line),
        .sda_o    (sda_out),
        .status_i (status),
        .vga_rgb_i(vga_rgb),
        .gpio_i   (gpio),
        .i2s_i    (i2s),
        .cdbus_i  (cdbus),
        .cfg_o    (cfg),
        .pad_o    (pad),
        .audio_o  (audio),
        .audio_t_o(audio_t)
    );

    initial begin
        clk_25m = 1'b0;
        forever #4 clk_25m = ~clk_25m;
    end

    task automatic tick(input int n);
        repeat (n) @(posedge clk_25m);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch %s expected 0x%0h got 0x%0h", name, exp, act);
            errs_now++;
        end
    endtask

    task automatic check_ack(input logic ack, input logic exp_ack, input string what);
        if (ack !== exp_ack) begin
            if (exp_ack)
                $display("no ACK from the slave on the %s byte", what);
            else
                $display("slave acknowledged the %s byte of a foreign address", what);
            errs_now++;
        end
    endtask

    // SCL is low on entry and on exit
    task automatic send_bit(input logic b, output logic seen);
        tick(4);
        sda_drv <= b;
        tick(PHASE - 4);
        scl <= 1'b1;
        tick(PHASE / 2);
        seen = sda_line;
        tick(PHASE / 2);
        scl <= 1'b0;
    endtask

    // Ninth bit, polled while SCL is high
    task automatic get_ack(output logic ack);
        int t;
        tick(4);
        sda_drv <= 1'b1;
        tick(PHASE - 4);
        scl <= 1'b1;
        ack = 1'b0;
        t = 0;
        while (!ack && t < PHASE) begin
            @(posedge clk_25m);
            ack = !sda_line;
            t++;
        end
        tick(PHASE - t);
        scl <= 1'b0;
    endtask

    task automatic send_start();
        tick(4);
        sda_drv <= 1'b1;
        tick(PHASE - 4);
        scl <= 1'b1;
        tick(PHASE);
        sda_drv <= 1'b0;
        tick(PHASE);
        scl <= 1'b0;
    endtask

    task automatic send_stop();
        tick(4);
        sda_drv <= 1'b0;
        tick(PHASE - 4);
        scl <= 1'b1;
        tick(PHASE);
        sda_drv <= 1'b1;
        tick(PHASE);
    endtask

    task automatic write_byte(input logic [7:0] b, output logic ack);
        logic seen;
        for (int i = 7; i >= 0; i--) begin
            send_bit(b[i], seen);
        end
        get_ack(ack);
    endtask

    task automatic read_byte(input logic last, output logic [7:0] b);
        logic seen;
        for (int i = 7; i >= 0; i--) begin
            send_bit(1'b1, seen);
            b[i] = seen;
        end
        send_bit(last, seen);   // NACK after the last byte
    endtask

    task automatic run_write(input logic [6:0] addr, input logic exp_ack,
                             input logic [3:0] ptr);
        logic ack;
        send_start();
        write_byte({addr, 1'b0}, ack);
        check_ack(ack, exp_ack, "address");
        write_byte({4'h0, ptr}, ack);
        check_ack(ack, exp_ack, "pointer");
        for (int i = 0; i < data_cnt; i++) begin
            write_byte(data_buf[i], ack);
            check_ack(ack, exp_ack, "data");
        end
        send_stop();
    endtask

    task automatic run_read(input logic [6:0] addr, input logic [3:0] ptr);
        logic       ack;
        logic [7:0] got;
        send_start();
        write_byte({addr, 1'b0}, ack);
        check_ack(ack, 1'b1, "address");
        write_byte({4'h0, ptr}, ack);
        check_ack(ack, 1'b1, "pointer");
        send_start();           // Repeated start turns the bus around
        write_byte({addr, 1'b1}, ack);
        check_ack(ack, 1'b1, "read address");
        for (int i = 0; i < data_cnt; i++) begin
            read_byte(i == data_cnt - 1, got);
            check_value($sformatf("read byte %0d", i), {24'h0, data_buf[i]}, {24'h0, got});
        end
        send_stop();
    endtask

    task automatic read_cfg_field(input string name, output logic [31:0] val,
                                  output bit known);
        known = 1'b1;
        case (name)
            "cpu_pll_mul": val = {24'h0, cfg.cpu_pll_mul};
            "cpu_pll_div": val = {24'h0, cfg.cpu_pll_div};
            "soc_pll_mul": val = {24'h0, cfg.soc_pll_mul};
            "soc_pll_div": val = {24'h0, cfg.soc_pll_div};
            "pll_ctrl":    val = {24'h0, cfg.pll_ctrl};
            "spi_div":     val = {24'h0, cfg.spi_div};
            "dbg_ctrl":    val = {24'h0, cfg.dbg_ctrl};
            "output_mux":  val = {24'h0, cfg.output_mux};
            "ctrl_word":   val = cfg.ctrl_word;
            default: begin
                val   = '0;
                known = 1'b0;
            end
        endcase
    endtask

    initial begin
        int          fd;
        int          code;
        string       op;
        string       field;
        string       rest;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] val;
        bit          known;

        rst      = 1'b1;
        scl      = 1'b1;
        sda_drv  = 1'b1;
        status   = '0;
        vga_rgb  = 8'ha5;
        gpio     = 16'h3c0f;    // o 3c, t 0f
        i2s      = 3'b011;      // lrclk 0, sclk 1, sdata 1
        cdbus    = 4'b1001;     // tx 1, tx_t 0, tx_en 0, tx_en_t 1
        data_cnt = 0;
        errs_now = 0;
        n_tests  = 0;
        n_failed = 0;
        n_errors = 0;

        tick(4);
        rst <= 1'b0;
        tick(2);

        fd = $fopen("dv/sysctl_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file dv/sysctl_trace.txt");
            n_errors++;
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op.substr(0, 0) == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    errs_now = 0;
                    case (op)
                        "W", "R": begin
                            if (op == "W")
                                code = $fscanf(fd, "%h %h %h %d", f1, f2, f3, f4);
                            else
                                code = $fscanf(fd, "%h %h %d", f1, f3, f4);
                            data_cnt = (f4 > 16) ? 16 : int'(f4);
                            for (int i = 0; i < data_cnt; i++) begin
                                code = $fscanf(fd, "%h", data_buf[i]);
                            end
                            if (op == "W")
                                run_write(f1[6:0], f2[0], f3[3:0]);
                            else
                                run_read(f1[6:0], f3[3:0]);
                        end
                        "S": begin
                            code = $fscanf(fd, "%h", f1);
                            @(posedge clk_25m);
                            status <= f1;
                            tick(4);
                        end
                        "C": begin
                            code = $fscanf(fd, "%s %h", field, f1);
                            read_cfg_field(field, val, known);
                            if (!known) begin
                                $display("trace names an unknown cfg_o field %s", field);
                                errs_now++;
                            end else begin
                                check_value({"cfg_o.", field}, f1, val);
                            end
                        end
                        "P": begin
                            code = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                            data_buf[0] = f1[7:0];
                            data_cnt    = 1;
                            run_write(`SYSCTL_I2C_ADDR, 1'b1, `SYSCTL_REG_OUTPUT_MUX);
                            check_value("cfg_o.output_mux", f1, {24'h0, cfg.output_mux});
                            check_value("pad_o", f2, {16'h0, pad});
                            check_value("audio_o", f3, {29'h0, audio});
                            check_value("audio_t_o", f4, {29'h0, audio_t});
                        end
                        default: begin
                            $display("trace holds an unknown operation %s", op);
                            errs_now++;
                        end
                    endcase
                    n_tests++;
                    if (errs_now != 0)
                        n_failed++;
                    n_errors += errs_now;
                    $display("test %0d (%s) %s", n_tests, op, (errs_now == 0) ? "ok" : "failed");
                end
            end
            $fclose(fd);
        end

        if (dut.u_checker.fail_count != 0) begin
            $display("checker saw %0d assertion failures", dut.u_checker.fail_count);
            n_errors += dut.u_checker.fail_count;
        end
        $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, n_errors);
        if (n_errors == 0 && n_failed == 0 && n_tests > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/sysctl_trace.txt ====
# W addr ack reg count bytes | R addr reg count expected bytes | S status word
# C cfg field expected value | P output mux, expected pad_o, audio_o, audio_t_o (all hex)
C cpu_pll_mul 2e
C cpu_pll_div 22
C soc_pll_mul 1e
C soc_pll_div 21
C pll_ctrl 00
C spi_div 04
C dbg_ctrl 05
C output_mux 03
C ctrl_word 00000000
W 3c 1 07 3 00 11 22
C output_mux 00
C ctrl_word 00002211
S a1b2c3d4
W 3c 1 0a 4 5a 6b 77 99
C ctrl_word 6b5a2211
R 3c 0a 4 5a 6b d4 c3
W 3d 0 00 1 55
C cpu_pll_mul 2e
W 3c 1 0f 2 88 77
C cpu_pll_mul 77
C cpu_pll_div 22
P 00 3c0f 5 6
P 01 a500 5 6
P 02 3c0f 6 0
P 03 a500 6 0

// ==== compile.f ====
+incdir+rtl
rtl/sysctl_pkg.sv
rtl/sysctl_sync.sv
rtl/i2c_bus_frontend.sv
rtl/i2c_reg_slave.sv
rtl/ctrl_reg_bank.sv
rtl/pad_mux.sv
rtl/sysctl_top.sv
dv/sysctl_checker.sv
dv/sysctl_tb.sv

// ==== Bender.yml ====
package:
  name: sysctl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/sysctl_pkg.sv
      - rtl/sysctl_sync.sv
      - rtl/i2c_bus_frontend.sv
      - rtl/i2c_reg_slave.sv
      - rtl/ctrl_reg_bank.sv
      - rtl/pad_mux.sv
      - rtl/sysctl_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/sysctl_checker.sv
      - dv/sysctl_tb.sv
